// File: rtl/fma_pkg.sv
package fma_pkg;

    // fp32 field widths
    localparam int FP_WIDTH   = 32;
    localparam int EXP_WIDTH  = 8;
    localparam int FRAC_WIDTH = 23;
    localparam int SIG_WIDTH  = 24;

    localparam int EXP_BIAS = 127;
    localparam int EXP_MAX  = 255;

    localparam logic [FP_WIDTH-1:0] QNAN_DEFAULT = 32'hFFC00000;

    // carry + product + addend span + guard
    localparam int ACC_WIDTH = 76;
    // first discarded bit once the leading one sits at the acc msb
    localparam int RND_BIT   = ACC_WIDTH - 2 - FRAC_WIDTH;

    typedef logic        [FP_WIDTH-1:0]    fp32_t;
    typedef logic        [EXP_WIDTH-1:0]   exp_t;
    typedef logic signed [EXP_WIDTH+1:0]   exp_ext_t;
    typedef logic        [FRAC_WIDTH-1:0]  frac_t;
    typedef logic        [SIG_WIDTH-1:0]   sig_t;
    typedef logic        [2*SIG_WIDTH-1:0] prod_t;
    typedef logic        [ACC_WIDTH-1:0]   acc_t;
    typedef logic        [6:0]             shamt_t;

    // operand class bits
    typedef logic [5:0] fp_class_t;
    localparam int CLS_ZERO   = 0;
    localparam int CLS_INF    = 1;
    localparam int CLS_NAN    = 2;
    localparam int CLS_SNAN   = 3;
    localparam int CLS_NORMAL = 4;
    localparam int CLS_SIGN   = 5;

    typedef enum logic [2:0] {
        RNE = 3'b000,
        RTZ = 3'b001,
        RDN = 3'b010,
        RUP = 3'b011,
        RMM = 3'b100
    } round_mode_e;

endpackage

// File: rtl/fp_classify.sv
`timescale 1ns/1ps

module fp_classify
(
    input  fma_pkg::fp32_t     operand_i,
    output fma_pkg::fp_class_t class_o
);
    import fma_pkg::*;

    exp_t  exp_f;
    frac_t frac_f;
    logic  exp_ones;

    assign exp_f    = operand_i[FP_WIDTH-2 -: EXP_WIDTH];
    assign frac_f   = operand_i[FRAC_WIDTH-1:0];
    assign exp_ones = (exp_f == exp_t'(EXP_MAX));

    // subnormals report as zero, inputs get flushed here
    assign class_o[CLS_ZERO]   = (exp_f == '0);
    assign class_o[CLS_INF]    = exp_ones & (frac_f == '0);
    assign class_o[CLS_NAN]    = exp_ones & (frac_f != '0);
    // quiet bit clear
    assign class_o[CLS_SNAN]   = exp_ones & (frac_f != '0) & ~frac_f[FRAC_WIDTH-1];
    assign class_o[CLS_NORMAL] = (exp_f != '0) & ~exp_ones;
    assign class_o[CLS_SIGN]   = operand_i[FP_WIDTH-1];

endmodule

// File: rtl/lzc.sv
`timescale 1ns/1ps

module lzc
#(
    parameter int WIDTH = 76
)
(
    input  logic [WIDTH-1:0] value_i,
    output fma_pkg::shamt_t  count_o,
    output logic             zero_o
);
    import fma_pkg::*;

    // highest set bit wins since it is visited last
    always_comb
    begin
        count_o = shamt_t'(WIDTH);
        for (int i = 0; i < WIDTH; i++)
        begin
            if (value_i[i])
                count_o = shamt_t'(WIDTH - 1 - i);
        end
    end

    assign zero_o = ~|value_i;

endmodule

// File: rtl/fp_mul_stage.sv
`timescale 1ns/1ps

module fp_mul_stage
(
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic                 start_i,
    input  fma_pkg::fp32_t       a_i,
    input  fma_pkg::fp32_t       b_i,
    input  fma_pkg::fp32_t       c_i,
    input  fma_pkg::fp_class_t   a_class_i,
    input  fma_pkg::fp_class_t   b_class_i,
    input  fma_pkg::fp_class_t   c_class_i,
    input  logic                 sub_i,
    input  fma_pkg::round_mode_e rnd_i,
    output logic                 valid_o,
    output logic                 prod_sign_o,
    output fma_pkg::exp_ext_t    prod_exp_o,
    output fma_pkg::prod_t       prod_sig_o,
    output logic                 prod_inf_o,
    output logic                 prod_zero_o,
    output fma_pkg::fp32_t       nan_sel_o,
    output logic                 nan_hit_o,
    output logic                 invalid_o,
    output fma_pkg::fp32_t       c_eff_o,
    output fma_pkg::fp_class_t   c_class_o,
    output fma_pkg::round_mode_e rnd_o
);
    import fma_pkg::*;

    sig_t     a_sig;
    sig_t     b_sig;
    exp_ext_t p_exp;
    fp32_t    nan_pick;
    logic     inf_times_zero;
    logic     any_snan;

    function automatic fp32_t quiet(input fp32_t v);
        return {v[FP_WIDTH-1:FRAC_WIDTH], 1'b1, v[FRAC_WIDTH-2:0]};
    endfunction

    ////////////////////////////////////////////////////////////
    // product
    ////////////////////////////////////////////////////////////
    assign a_sig = a_class_i[CLS_NORMAL] ? {1'b1, a_i[FRAC_WIDTH-1:0]} : '0;
    assign b_sig = b_class_i[CLS_NORMAL] ? {1'b1, b_i[FRAC_WIDTH-1:0]} : '0;

    // biased exponent of the product with its hidden bit at 46
    assign p_exp = exp_ext_t'({2'b00, a_i[FP_WIDTH-2 -: EXP_WIDTH]})
                 + exp_ext_t'({2'b00, b_i[FP_WIDTH-2 -: EXP_WIDTH]})
                 - exp_ext_t'(EXP_BIAS);

    assign inf_times_zero = (a_class_i[CLS_INF] & b_class_i[CLS_ZERO])
                          | (a_class_i[CLS_ZERO] & b_class_i[CLS_INF]);
    assign any_snan = a_class_i[CLS_SNAN] | b_class_i[CLS_SNAN] | c_class_i[CLS_SNAN];

    // first nan wins, order a b c
    always_comb
    begin
        if (a_class_i[CLS_NAN])
            nan_pick = quiet(a_i);
        else if (b_class_i[CLS_NAN])
            nan_pick = quiet(b_i);
        else
            nan_pick = quiet(c_i);
    end

    ////////////////////////////////////////////////////////////
    // stage register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
            valid_o <= 1'b0;
        else
            valid_o <= start_i;
    end

    always_ff @(posedge clk_i)
    begin
        if (start_i)
        begin
            prod_sign_o <= a_class_i[CLS_SIGN] ^ b_class_i[CLS_SIGN];
            prod_exp_o  <= p_exp;
            prod_sig_o  <= a_sig * b_sig;
            prod_inf_o  <= a_class_i[CLS_INF] | b_class_i[CLS_INF];
            prod_zero_o <= a_class_i[CLS_ZERO] | b_class_i[CLS_ZERO];
            nan_sel_o   <= nan_pick;
            nan_hit_o   <= a_class_i[CLS_NAN] | b_class_i[CLS_NAN] | c_class_i[CLS_NAN];
            invalid_o   <= inf_times_zero | any_snan;
            c_eff_o     <= {c_i[FP_WIDTH-1] ^ sub_i, c_i[FP_WIDTH-2:0]};
            c_class_o   <= c_class_i;
            rnd_o       <= rnd_i;
        end
    end

endmodule

// File: rtl/fp_align_add.sv
`timescale 1ns/1ps

module fp_align_add
(
    input  logic              prod_sign_i,
    input  fma_pkg::exp_ext_t prod_exp_i,
    input  fma_pkg::prod_t    prod_sig_i,
    input  fma_pkg::fp32_t    c_eff_i,
    input  logic              c_zero_i,
    output fma_pkg::acc_t     sum_o,
    output logic              sum_sign_o,
    output fma_pkg::exp_ext_t sum_exp_o,
    output logic              exact_zero_o
);
    import fma_pkg::*;

    sig_t     c_sig;
    exp_ext_t c_exp;
    exp_ext_t diff;
    shamt_t   shamt;
    logic     prod_big;
    logic     eff_sub;
    logic     p_ge;
    logic     small_lost;
    acc_t     p_raw;
    acc_t     c_raw;
    acc_t     small_raw;
    acc_t     small_jam;
    acc_t     p_al;
    acc_t     c_al;

    assign c_sig = c_zero_i ? '0 : {1'b1, c_eff_i[FRAC_WIDTH-1:0]};
    assign c_exp = exp_ext_t'({2'b00, c_eff_i[FP_WIDTH-2 -: EXP_WIDTH]});

    // both hidden bits land on ACC_WIDTH-3
    assign p_raw = {1'b0, prod_sig_i, {(ACC_WIDTH-1-2*SIG_WIDTH){1'b0}}};
    assign c_raw = {2'b00, c_sig, {(ACC_WIDTH-2-SIG_WIDTH){1'b0}}};

    ////////////////////////////////////////////////////////////
    // align
    ////////////////////////////////////////////////////////////
    // a zero term never sets the reference exponent
    assign prod_big = c_zero_i | ((prod_sig_i != '0) & (prod_exp_i >= c_exp));
    assign diff     = prod_big ? (prod_exp_i - c_exp) : (c_exp - prod_exp_i);

    always_comb
    begin
        if (diff < 0 || diff > exp_ext_t'(ACC_WIDTH))
            shamt = shamt_t'(ACC_WIDTH);
        else
            shamt = shamt_t'(diff);
    end

    assign small_raw  = prod_big ? c_raw : p_raw;
    assign small_lost = |(small_raw & ~({ACC_WIDTH{1'b1}} << shamt));

    // far bits collapse into the lsb
    always_comb
    begin
        small_jam    = small_raw >> shamt;
        small_jam[0] = small_jam[0] | small_lost;
    end

    assign p_al = prod_big ? p_raw : small_jam;
    assign c_al = prod_big ? small_jam : c_raw;

    ////////////////////////////////////////////////////////////
    // add / subtract
    ////////////////////////////////////////////////////////////
    assign eff_sub = prod_sign_i ^ c_eff_i[FP_WIDTH-1];
    assign p_ge    = (p_al >= c_al);

    always_comb
    begin
        if (!eff_sub)
            sum_o = p_al + c_al;
        else if (p_ge)
            sum_o = p_al - c_al;
        else
            sum_o = c_al - p_al;
    end

    assign sum_sign_o   = p_ge ? prod_sign_i : c_eff_i[FP_WIDTH-1];
    assign sum_exp_o    = prod_big ? prod_exp_i : c_exp;
    assign exact_zero_o = (sum_o == '0);

endmodule

// File: rtl/fp_normalize_stage.sv
`timescale 1ns/1ps

module fp_normalize_stage
(
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic                 valid_i,
    input  fma_pkg::acc_t        sum_i,
    input  logic                 sum_sign_i,
    input  fma_pkg::exp_ext_t    sum_exp_i,
    input  logic                 exact_zero_i,
    input  logic                 prod_inf_i,
    input  logic                 prod_zero_i,
    input  logic                 prod_sign_i,
    input  fma_pkg::fp32_t       nan_sel_i,
    input  logic                 nan_hit_i,
    input  logic                 invalid_i,
    input  fma_pkg::fp32_t       c_eff_i,
    input  fma_pkg::fp_class_t   c_class_i,
    input  fma_pkg::round_mode_e rnd_i,
    output fma_pkg::fp32_t       result_o,
    output logic [1:0]           rs_o,
    output logic                 round_en_o,
    output logic                 invalid_o,
    output logic                 ovf_o,
    output logic                 uf_o,
    output logic                 done_o
);
    import fma_pkg::*;

    shamt_t   lz_count;
    logic     lz_zero;
    acc_t     norm;
    exp_ext_t norm_exp;
    logic     inf_clash;
    logic     zero_sign;
    fp32_t    res_d;
    logic [1:0] rs_d;
    logic     round_en_d;
    logic     invalid_d;
    logic     ovf_d;
    logic     uf_d;

    lzc #(.WIDTH(ACC_WIDTH)) u_lzc
    (
        .value_i (sum_i),
        .count_o (lz_count),
        .zero_o  (lz_zero)
    );

    // leading one to the msb, reference hidden bit sits two below it
    assign norm     = lz_zero ? '0 : (sum_i << lz_count);
    assign norm_exp = sum_exp_i + exp_ext_t'(2) - exp_ext_t'({3'b000, lz_count});

    assign inf_clash = prod_inf_i & c_class_i[CLS_INF] & (prod_sign_i ^ c_eff_i[FP_WIDTH-1]);
    assign zero_sign = (prod_zero_i && c_class_i[CLS_ZERO] &&
                        prod_sign_i == c_eff_i[FP_WIDTH-1]) ? prod_sign_i : (rnd_i == RDN);

    ////////////////////////////////////////////////////////////
    // special case priority
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        res_d      = '0;
        rs_d       = 2'b00;
        round_en_d = 1'b0;
        invalid_d  = invalid_i;
        ovf_d      = 1'b0;
        uf_d       = 1'b0;
        if (nan_hit_i || invalid_i)
            res_d = nan_hit_i ? nan_sel_i : QNAN_DEFAULT;
        else if (inf_clash)
        begin
            res_d     = QNAN_DEFAULT;
            invalid_d = 1'b1;
        end
        else if (prod_inf_i)
            res_d = {prod_sign_i, exp_t'(EXP_MAX), {FRAC_WIDTH{1'b0}}};
        else if (c_class_i[CLS_INF])
            res_d = c_eff_i;
        else if (exact_zero_i)
            res_d = {zero_sign, {(FP_WIDTH-1){1'b0}}};
        else if (norm_exp > exp_ext_t'(EXP_MAX - 1))
        begin
            res_d = {sum_sign_i, exp_t'(EXP_MAX), {FRAC_WIDTH{1'b0}}};
            ovf_d = 1'b1;
        end
        else if (norm_exp < exp_ext_t'(1))
        begin
            // flush to zero
            res_d = {sum_sign_i, {(FP_WIDTH-1){1'b0}}};
            uf_d  = 1'b1;
        end
        else
        begin
            res_d      = {sum_sign_i, norm_exp[EXP_WIDTH-1:0], norm[ACC_WIDTH-2 -: FRAC_WIDTH]};
            rs_d       = {norm[RND_BIT], |norm[RND_BIT-1:0]};
            round_en_d = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            done_o     <= 1'b0;
            round_en_o <= 1'b0;
            invalid_o  <= 1'b0;
            ovf_o      <= 1'b0;
            uf_o       <= 1'b0;
        end
        else
        begin
            done_o <= valid_i;
            if (valid_i)
            begin
                round_en_o <= round_en_d;
                invalid_o  <= invalid_d;
                ovf_o      <= ovf_d;
                uf_o       <= uf_d;
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (valid_i)
        begin
            result_o <= res_d;
            rs_o     <= rs_d;
        end
    end

endmodule

// File: rtl/fp_fma_top.sv
`timescale 1ns/1ps

module fp_fma_top
(
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  fma_pkg::fp32_t       a_i,
    input  fma_pkg::fp32_t       b_i,
    input  fma_pkg::fp32_t       c_i,
    input  logic                 sub_i,
    input  fma_pkg::round_mode_e rnd_i,
    input  logic                 start_i,
    output fma_pkg::fp32_t       result_o,
    output logic [1:0]           rs_o,
    output logic                 round_en_o,
    output logic                 invalid_o,
    output logic                 ovf_o,
    output logic                 uf_o,
    output logic                 done_o
);
    import fma_pkg::*;

    fp_class_t   a_class;
    fp_class_t   b_class;
    fp_class_t   c_class;

    // stage one registers
    logic        s1_valid;
    logic        s1_prod_sign;
    exp_ext_t    s1_prod_exp;
    prod_t       s1_prod_sig;
    logic        s1_prod_inf;
    logic        s1_prod_zero;
    fp32_t       s1_nan_sel;
    logic        s1_nan_hit;
    logic        s1_invalid;
    fp32_t       s1_c_eff;
    fp_class_t   s1_c_class;
    round_mode_e s1_rnd;

    acc_t        sum;
    logic        sum_sign;
    exp_ext_t    sum_exp;
    logic        exact_zero;

    fp_classify u_class_a (.operand_i(a_i), .class_o(a_class));
    fp_classify u_class_b (.operand_i(b_i), .class_o(b_class));
    fp_classify u_class_c (.operand_i(c_i), .class_o(c_class));

    fp_mul_stage u_mul
    (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .start_i     (start_i),
        .a_i         (a_i),
        .b_i         (b_i),
        .c_i         (c_i),
        .a_class_i   (a_class),
        .b_class_i   (b_class),
        .c_class_i   (c_class),
        .sub_i       (sub_i),
        .rnd_i       (rnd_i),
        .valid_o     (s1_valid),
        .prod_sign_o (s1_prod_sign),
        .prod_exp_o  (s1_prod_exp),
        .prod_sig_o  (s1_prod_sig),
        .prod_inf_o  (s1_prod_inf),
        .prod_zero_o (s1_prod_zero),
        .nan_sel_o   (s1_nan_sel),
        .nan_hit_o   (s1_nan_hit),
        .invalid_o   (s1_invalid),
        .c_eff_o     (s1_c_eff),
        .c_class_o   (s1_c_class),
        .rnd_o       (s1_rnd)
    );

    fp_align_add u_align_add
    (
        .prod_sign_i  (s1_prod_sign),
        .prod_exp_i   (s1_prod_exp),
        .prod_sig_i   (s1_prod_sig),
        .c_eff_i      (s1_c_eff),
        .c_zero_i     (s1_c_class[CLS_ZERO]),
        .sum_o        (sum),
        .sum_sign_o   (sum_sign),
        .sum_exp_o    (sum_exp),
        .exact_zero_o (exact_zero)
    );

    fp_normalize_stage u_norm
    (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .valid_i      (s1_valid),
        .sum_i        (sum),
        .sum_sign_i   (sum_sign),
        .sum_exp_i    (sum_exp),
        .exact_zero_i (exact_zero),
        .prod_inf_i   (s1_prod_inf),
        .prod_zero_i  (s1_prod_zero),
        .prod_sign_i  (s1_prod_sign),
        .nan_sel_i    (s1_nan_sel),
        .nan_hit_i    (s1_nan_hit),
        .invalid_i    (s1_invalid),
        .c_eff_i      (s1_c_eff),
        .c_class_i    (s1_c_class),
        .rnd_i        (s1_rnd),
        .result_o     (result_o),
        .rs_o         (rs_o),
        .round_en_o   (round_en_o),
        .invalid_o    (invalid_o),
        .ovf_o        (ovf_o),
        .uf_o         (uf_o),
        .done_o       (done_o)
    );

endmodule

// File: sim/fma_checker.sv
`timescale 1ns/1ps

module fma_checker
(
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  fma_pkg::fp32_t       a_i,
    input  fma_pkg::fp32_t       b_i,
    input  fma_pkg::fp32_t       c_i,
    input  logic                 sub_i,
    input  fma_pkg::round_mode_e rnd_i,
    input  logic                 start_i,
    input  fma_pkg::fp32_t       result_i,
    input  logic [1:0]           rs_i,
    input  logic                 round_en_i,
    input  logic                 invalid_i,
    input  logic                 ovf_i,
    input  logic                 uf_i,
    input  logic                 done_i,
    output int                   err_count_o,
    output int                   checked_o,
    output int                   pending_o
);
    import fma_pkg::*;

    // expected results, oldest first
    logic [31:0] res_q[$];
    logic [1:0]  rs_q[$];
    logic [3:0]  flag_q[$];
    int          due_q[$];

    int          cycle = 0;
    int          errors = 0;
    int          checked = 0;
    int          pending = 0;
    logic        seen_start = 1'b0;

    assign err_count_o = errors;
    assign checked_o   = checked;
    assign pending_o   = pending;

    function automatic logic is_nan(input logic [31:0] x);
        return (x[30:23] == 8'hFF) && (x[22:0] != 23'h0);
    endfunction

    function automatic logic is_snan(input logic [31:0] x);
        return is_nan(x) && !x[22];
    endfunction

    function automatic logic is_inf(input logic [31:0] x);
        return (x[30:23] == 8'hFF) && (x[22:0] == 23'h0);
    endfunction

    // subnormals count as zero
    function automatic logic is_zero(input logic [31:0] x);
        return x[30:23] == 8'h00;
    endfunction

    function automatic logic [23:0] hidden_sig(input logic [31:0] x);
        return (!is_zero(x) && x[30:23] != 8'hFF) ? {1'b1, x[22:0]} : 24'h0;
    endfunction

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////
    task automatic compute_expected(
        input  logic [31:0] a,
        input  logic [31:0] b,
        input  logic [31:0] c,
        input  logic        sub,
        input  round_mode_e rnd,
        output logic [31:0] res,
        output logic [1:0]  rs,
        output logic [3:0]  flags
    );
        logic [31:0]  ce;
        logic         ps;
        logic         nan_any;
        logic         inv;
        logic         p_inf;
        logic         p_zero;
        logic [511:0] pm;
        logic [511:0] cm;
        logic [511:0] mag;
        logic         ms;
        int           pe;
        int           qe;
        int           e0;
        int           msb;
        int           bexp;
        ce      = {c[31] ^ sub, c[30:0]};
        ps      = a[31] ^ b[31];
        res     = 32'h0;
        rs      = 2'b00;
        flags   = 4'b0000;
        nan_any = is_nan(a) | is_nan(b) | is_nan(c);
        inv     = is_snan(a) | is_snan(b) | is_snan(c)
                | (is_inf(a) & is_zero(b)) | (is_zero(a) & is_inf(b));
        p_inf   = is_inf(a) | is_inf(b);
        p_zero  = is_zero(a) | is_zero(b);
        flags[2] = inv;
        if (nan_any || inv)
        begin
            if (is_nan(a))
                res = a | 32'h0040_0000;
            else if (is_nan(b))
                res = b | 32'h0040_0000;
            else if (is_nan(c))
                res = c | 32'h0040_0000;
            else
                res = 32'hFFC0_0000;
        end
        else if (p_inf && is_inf(c) && (ps != ce[31]))
        begin
            res      = 32'hFFC0_0000;
            flags[2] = 1'b1;
        end
        else if (p_inf)
            res = {ps, 8'hFF, 23'h0};
        else if (is_inf(c))
            res = ce;
        else
        begin
            // value = m * 2^e, both terms as exact integers
            pm = 512'(hidden_sig(a)) * 512'(hidden_sig(b));
            cm = 512'(hidden_sig(c));
            pe = int'(a[30:23]) + int'(b[30:23]) - 300;
            qe = int'(c[30:23]) - 150;
            if (pm == '0)
                e0 = qe;
            else if (cm == '0)
                e0 = pe;
            else
                e0 = (pe < qe) ? pe : qe;
            if (pm != '0)
                pm = pm << (pe - e0);
            if (cm != '0)
                cm = cm << (qe - e0);
            if (ps == ce[31])
            begin
                mag = pm + cm;
                ms  = ps;
            end
            else if (pm >= cm)
            begin
                mag = pm - cm;
                ms  = ps;
            end
            else
            begin
                mag = cm - pm;
                ms  = ce[31];
            end
            if (mag == '0)
            begin
                if (p_zero && is_zero(c) && ps == ce[31])
                    res = {ps, 31'h0};
                else
                    res = {rnd == RDN, 31'h0};
            end
            else
            begin
                msb = 0;
                for (int i = 0; i < 512; i++)
                begin
                    if (mag[i])
                        msb = i;
                end
                bexp = e0 + msb + 127;
                if (bexp > 254)
                begin
                    res      = {ms, 8'hFF, 23'h0};
                    flags[1] = 1'b1;
                end
                else if (bexp < 1)
                begin
                    res      = {ms, 31'h0};
                    flags[0] = 1'b1;
                end
                else
                begin
                    // leading one to bit 511, then truncate
                    mag      = mag << (511 - msb);
                    res      = {ms, bexp[7:0], mag[510:488]};
                    rs       = {mag[487], |mag[486:0]};
                    flags[3] = 1'b1;
                end
            end
        end
    endtask

    task automatic check_value(
        input string       name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        if (expected !== actual)
        begin
            errors = errors + 1;
            $display("ERROR: %s expected %h, got %h at cycle %0d",
                     name, expected, actual, cycle);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // monitor
    ////////////////////////////////////////////////////////////
    always @(posedge clk_i)
        cycle <= cycle + 1;

    always @(negedge clk_i)
    begin : check_blk
        logic [31:0] e_res;
        logic [1:0]  e_rs;
        logic [3:0]  e_flags;
        if (arst_n_i)
        begin
            if (!seen_start && (done_i || round_en_i || invalid_i || ovf_i || uf_i))
            begin
                errors = errors + 1;
                $display("done_o or a flag went high before the first start, cycle %0d", cycle);
            end
            if (done_i)
            begin
                if (due_q.size() == 0)
                begin
                    errors = errors + 1;
                    $display("done_o pulsed with no operation pending, cycle %0d", cycle);
                end
                else
                begin
                    if (due_q[0] != cycle)
                    begin
                        errors = errors + 1;
                        $display("done_o came at cycle %0d, expected at cycle %0d",
                                 cycle, due_q[0]);
                    end
                    e_res   = res_q.pop_front();
                    e_rs    = rs_q.pop_front();
                    e_flags = flag_q.pop_front();
                    void'(due_q.pop_front());
                    check_value("result_o", e_res, result_i);
                    check_value("rs_o", 32'(e_rs), 32'(rs_i));
                    check_value("round_en_o", 32'(e_flags[3]), 32'(round_en_i));
                    check_value("invalid_o", 32'(e_flags[2]), 32'(invalid_i));
                    check_value("ovf_o", 32'(e_flags[1]), 32'(ovf_i));
                    check_value("uf_o", 32'(e_flags[0]), 32'(uf_i));
                    checked = checked + 1;
                end
            end
            else if (due_q.size() != 0 && due_q[0] <= cycle)
            begin
                errors = errors + 1;
                $display("done_o missing at cycle %0d", cycle);
                void'(res_q.pop_front());
                void'(rs_q.pop_front());
                void'(flag_q.pop_front());
                void'(due_q.pop_front());
            end
            // accepted on the next rising edge
            if (start_i)
            begin
                compute_expected(a_i, b_i, c_i, sub_i, rnd_i, e_res, e_rs, e_flags);
                res_q.push_back(e_res);
                rs_q.push_back(e_rs);
                flag_q.push_back(e_flags);
                due_q.push_back(cycle + 2);
                seen_start = 1'b1;
            end
            pending = due_q.size();
        end
    end

endmodule

// File: sim/tb_fp_fma.sv
`timescale 1ns/1ps

module tb_fp_fma;
    import fma_pkg::*;

    localparam int NUM_OPS      = 400;
    localparam int RESET_CYCLES = 5;
    localparam int IDLE_EVERY   = 32;
    localparam int WATCHDOG_NS  =
        (RESET_CYCLES + 3 + NUM_OPS + NUM_OPS / IDLE_EVERY + 20) * 100;

    logic        clk;
    logic        arst_n;
    fp32_t       a;
    fp32_t       b;
    fp32_t       c;
    logic        sub;
    round_mode_e rnd;
    logic        start;
    fp32_t       result;
    logic [1:0]  rs;
    logic        round_en;
    logic        invalid;
    logic        ovf;
    logic        uf;
    logic        done;
    int          err_count;
    int          checked;
    int          pending;

    always #50 clk = ~clk;

    fp_fma_top UUT
    (
        .clk_i      (clk),
        .arst_n_i   (arst_n),
        .a_i        (a),
        .b_i        (b),
        .c_i        (c),
        .sub_i      (sub),
        .rnd_i      (rnd),
        .start_i    (start),
        .result_o   (result),
        .rs_o       (rs),
        .round_en_o (round_en),
        .invalid_o  (invalid),
        .ovf_o      (ovf),
        .uf_o       (uf),
        .done_o     (done)
    );

    fma_checker u_checker
    (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .a_i         (a),
        .b_i         (b),
        .c_i         (c),
        .sub_i       (sub),
        .rnd_i       (rnd),
        .start_i     (start),
        .result_i    (result),
        .rs_i        (rs),
        .round_en_i  (round_en),
        .invalid_i   (invalid),
        .ovf_i       (ovf),
        .uf_i        (uf),
        .done_i      (done),
        .err_count_o (err_count),
        .checked_o   (checked),
        .pending_o   (pending)
    );

    function automatic fp32_t rand_normal(input int lo, input int hi);
        logic [31:0] r;
        logic [31:0] f;
        int          e;
        r = $urandom;
        f = $urandom;
        e = lo + int'(r[15:0]) % (hi - lo + 1);
        return {r[31], e[7:0], f[22:0]};
    endfunction

    function automatic fp32_t pick_special();
        logic [31:0] r;
        logic [31:0] f;
        fp32_t       v;
        r = $urandom;
        f = $urandom;
        case (r[2:0])
            3'd0: v = {r[3], 31'h0};
            3'd1: v = {r[3], 8'hFF, 23'h0};
            3'd2: v = {r[3], 8'hFF, 1'b1, f[21:0]};
            3'd3: v = {r[3], 8'hFF, 1'b0, f[21:1], 1'b1};
            3'd4: v = {r[3], 8'h00, f[22:0]};
            default: v = rand_normal(100, 154);
        endcase
        return v;
    endfunction

    function automatic round_mode_e mode_from(input logic [31:0] v);
        round_mode_e m;
        case (v % 32'd5)
            32'd0: m = RNE;
            32'd1: m = RTZ;
            32'd2: m = RDN;
            32'd3: m = RUP;
            default: m = RMM;
        endcase
        return m;
    endfunction

    task automatic build_operation();
        logic [31:0] r;
        logic [31:0] f;
        int          ce;
        r   = $urandom;
        f   = $urandom;
        sub = r[4];
        rnd = mode_from(r >> 16);
        case (r[3:0])
            4'd6:
            begin
                // infinite product against an infinite addend
                a = {r[13], 8'hFF, 23'h0};
                b = rand_normal(1, 254);
                c = {r[14], 8'hFF, 23'h0};
            end
            4'd7:
            begin
                a = rand_normal(1, 254);
                b = rand_normal(1, 254);
                c = rand_normal(1, 254);
            end
            4'd8, 4'd9:
            begin
                // b a power of two so c cancels the product exactly or nearly
                a  = rand_normal(100, 154);
                b  = rand_normal(120, 134) & 32'hFF80_0000;
                ce = int'(a[30:23]) + int'(b[30:23]) - 127;
                c  = {a[31] ^ b[31] ^ ~sub, ce[7:0], a[22:0]};
                if (r[12])
                    c[0] = ~c[0];
            end
            4'd10:
            begin
                a = rand_normal(200, 254);
                b = rand_normal(200, 254);
                c = rand_normal(1, 254);
            end
            4'd11:
            begin
                a = rand_normal(1, 50);
                b = rand_normal(1, 50);
                c = {r[13], 8'h00, r[14] ? 23'h0 : f[22:0]};
            end
            4'd12, 4'd13, 4'd14, 4'd15:
            begin
                a = pick_special();
                b = pick_special();
                c = pick_special();
            end
            default:
            begin
                a = rand_normal(100, 154);
                b = rand_normal(100, 154);
                c = rand_normal(60, 200);
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////
    initial
    begin
        void'($urandom(32'h32b0_e5c4));
        clk    = 1'b0;
        arst_n = 1'b0;
        start  = 1'b0;
        a      = '0;
        b      = '0;
        c      = '0;
        sub    = 1'b0;
        rnd    = RNE;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 arst_n = 1'b1;
        // quiet cycles before the first start
        repeat (3) @(posedge clk);
        for (int i = 0; i < NUM_OPS; i++)
        begin
            #1;
            build_operation();
            start = 1'b1;
            @(posedge clk);
            if (i % IDLE_EVERY == IDLE_EVERY - 1)
            begin
                #1 start = 1'b0;
                @(posedge clk);
            end
        end
        #1 start = 1'b0;
        while (pending != 0)
            @(posedge clk);
        repeat (3) @(posedge clk);
        if (checked != NUM_OPS)
            $display("only %0d of %0d operations were checked", checked, NUM_OPS);
        $display("checks: %0d, errors: %0d", checked, err_count);
        if (err_count == 0 && checked == NUM_OPS)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the DUT stopped answering", WATCHDOG_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: verilog.f
rtl/fma_pkg.sv
rtl/fp_classify.sv
rtl/lzc.sv
rtl/fp_mul_stage.sv
rtl/fp_align_add.sv
rtl/fp_normalize_stage.sv
rtl/fp_fma_top.sv
sim/fma_checker.sv
sim/tb_fp_fma.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile with Verilator, run, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module tb_fp_fma -o sim_fma \
    && ./obj_dir/sim_fma | tee /dev/stderr | grep -qF "*** TEST PASSED ***" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
